// ==== Makefile ====
# Verilator build and run of the cpuAddrGen testbench

.PHONY: run clean

SIM = obj_dir/VcpuAddrGenTb

# Rebuilt only when the file list or a source changes
$(SIM): build.f $(wildcard logic/*.sv) $(wildcard test/*.sv)
	verilator --binary --assert --timescale 1ns/1ps --top-module cpuAddrGenTb \
		-Mdir obj_dir -f build.f

# The log decides pass or fail
run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== build.f ====
logic/addrGenPkg.sv
logic/cpuPhaseGen.sv
logic/mainDecode.sv
logic/subDecode.sv
logic/vblankSupervisor.sv
logic/cpuAddrGen.sv
test/cpuAddrGenTb.sv

// ==== logic/addrGenPkg.sv ====
`default_nettype none

package addrGenPkg;

	//////////////////////////////////////////////////////////////////////
	// Types
	//////////////////////////////////////////////////////////////////////

	// Upper address lines 15:11, one 2 KB page per code
	typedef logic [15:11] addrPage_t;

	// CPU phase counter, wraps at 16
	typedef logic [3:0] phaseCount_t;

	//////////////////////////////////////////////////////////////////////
	// Main CPU register pages
	//////////////////////////////////////////////////////////////////////

	// Watchdog kick, write to 8000h
	localparam addrPage_t pageWdKick = 5'b10000;

	// Main interrupt acknowledge, write to 8800h
	localparam addrPage_t pageMainAck = 5'b10001;

	// Scroll and priority latch 0, D000h-D7FFh
	// Also carries the bank select of ROM 9D
	localparam addrPage_t pageLatch0 = 5'b11010;

	// Scroll and priority latch 1, D800h-DFFFh
	localparam addrPage_t pageLatch1 = 5'b11011;

	//////////////////////////////////////////////////////////////////////
	// Sub CPU register pages
	//////////////////////////////////////////////////////////////////////

	// Sub interrupt acknowledge, write to 8800h
	localparam addrPage_t pageSubAck = 5'b10001;

	// Sound chip, writes to 9000h-97FFh
	localparam addrPage_t pageSound = 5'b10010;

endpackage

`default_nettype wire

// ==== logic/cpuAddrGen.sv ====
`default_nettype none

module cpuAddrGen #(
	parameter int wdWidth = 4,
	parameter int wdLimit = 10
) (
	input wire logic clk6M,
	input wire logic rstN,
	input wire logic clk0,
	input wire addrGenPkg::addrPage_t ma,
	input wire logic nMwe,
	input wire addrGenPkg::addrPage_t sa,
	input wire logic nSwe,
	input wire logic nVbla,
	output logic q,
	output logic nMCs0,
	output logic nMCs1,
	output logic nMCs2,
	output logic nMCs4,
	output logic nMRom,
	output logic nLth0,
	output logic nLth1,
	output logic nSCs0,
	output logic nSCs1,
	output logic nSCs2,
	output logic nSCs4,
	output logic nSRom,
	output logic nSnd,
	output logic nMReset,
	output logic nMInt,
	output logic nSInt
);

	// Decoder strobes into the supervisor
	logic wdKick;
	logic mainAck;
	logic subAck;

	// CPU E/Q phase
	cpuPhaseGen phaseGen_i (
		.clk6M (clk6M),
		.rstN  (rstN),
		.clk0  (clk0),
		.q     (q)
	);

	// Main CPU map
	mainDecode mainDecode_i (
		.ma      (ma),
		.nMwe    (nMwe),
		.nMCs0   (nMCs0),
		.nMCs1   (nMCs1),
		.nMCs2   (nMCs2),
		.nMCs4   (nMCs4),
		.nMRom   (nMRom),
		.nLth0   (nLth0),
		.nLth1   (nLth1),
		.wdKick  (wdKick),
		.mainAck (mainAck)
	);

	// Sub CPU map
	subDecode subDecode_i (
		.sa     (sa),
		.nSwe   (nSwe),
		.nSCs0  (nSCs0),
		.nSCs1  (nSCs1),
		.nSCs2  (nSCs2),
		.nSCs4  (nSCs4),
		.nSRom  (nSRom),
		.nSnd   (nSnd),
		.subAck (subAck)
	);

	// Watchdog and vblank interrupts
	vblankSupervisor #(
		.wdWidth (wdWidth),
		.wdLimit (wdLimit)
	) supervisor_i (
		.clk6M   (clk6M),
		.rstN    (rstN),
		.nVbla   (nVbla),
		.wdKick  (wdKick),
		.mainAck (mainAck),
		.subAck  (subAck),
		.nMReset (nMReset),
		.nMInt   (nMInt),
		.nSInt   (nSInt)
	);

endmodule

`default_nettype wire

// ==== logic/cpuPhaseGen.sv ====
`default_nettype none

module cpuPhaseGen (
	input wire logic clk6M,
	input wire logic rstN,
	input wire logic clk0,
	output logic q
);

	// Free running count of 6 MHz edges since clk0 last went high
	addrGenPkg::phaseCount_t phaseCnt;

	//////////////////////////////////////////////////////////////////////
	// Phase counter
	//////////////////////////////////////////////////////////////////////

	// Models the 74LS161 stage on the board
	// clk0 low acts as a synchronous clear, so the counter
	// lines up with the external clock generator every cycle
	always_ff @(posedge clk6M or negedge rstN) begin
		if (!rstN) begin
			phaseCnt <= '0;
		end else if (!clk0) begin
			// Held while clk0 is low
			phaseCnt <= '0;
		end else begin
			// Wraps at 16 on its own
			phaseCnt <= phaseCnt + 4'd1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Quadrature output
	//////////////////////////////////////////////////////////////////////

	// Bit 1 is the divided 6 MHz clock
	// Xor with bit 0 shifts it by one count, a quarter period
	assign q = phaseCnt[1] ^ phaseCnt[0];

endmodule

`default_nettype wire

// ==== logic/mainDecode.sv ====
`default_nettype none

module mainDecode (
	input wire addrGenPkg::addrPage_t ma,
	input wire logic nMwe,
	output logic nMCs0,
	output logic nMCs1,
	output logic nMCs2,
	output logic nMCs4,
	output logic nMRom,
	output logic nLth0,
	output logic nLth1,
	output logic wdKick,
	output logic mainAck
);

	// Read and write qualifiers from the CPU write level
	logic isRead;
	logic isWrite;

	// 8 KB region from lines 15:13
	logic [15:13] region;

	assign isRead = nMwe;
	assign isWrite = ~nMwe;
	assign region = ma[15:13];

	//////////////////////////////////////////////////////////////////////
	// RAM and ROM selects
	//////////////////////////////////////////////////////////////////////

	// 0000h-1FFFh, sprite RAM
	assign nMCs2 = ~(region == 3'b000);

	// 2000h-3FFFh, video RAM 1
	assign nMCs0 = ~(region == 3'b001);

	// 4000h-5FFFh, video RAM 2
	assign nMCs1 = ~(region == 3'b010);

	// 6000h-7FFFh, banked program ROM
	// Only on reads
	assign nMCs4 = ~(isRead & (region == 3'b011));

	// 8000h-FFFFh, fixed program ROM
	// Writes into this half go to the register pages below
	assign nMRom = ~(isRead & ma[15]);

	//////////////////////////////////////////////////////////////////////
	// Latch strobes
	//////////////////////////////////////////////////////////////////////

	// Scroll, priority and ROM bank registers
	// Write only, active low
	assign nLth0 = ~(isWrite & (ma == addrGenPkg::pageLatch0));
	assign nLth1 = ~(isWrite & (ma == addrGenPkg::pageLatch1));

	//////////////////////////////////////////////////////////////////////
	// Internal strobes
	//////////////////////////////////////////////////////////////////////

	// Watchdog kick, any write to the 8000h page
	assign wdKick = isWrite & (ma == addrGenPkg::pageWdKick);

	// Main vblank interrupt acknowledge
	assign mainAck = isWrite & (ma == addrGenPkg::pageMainAck);

endmodule

`default_nettype wire

// ==== logic/subDecode.sv ====
`default_nettype none

module subDecode (
	input wire addrGenPkg::addrPage_t sa,
	input wire logic nSwe,
	output logic nSCs0,
	output logic nSCs1,
	output logic nSCs2,
	output logic nSCs4,
	output logic nSRom,
	output logic nSnd,
	output logic subAck
);

	// Read and write qualifiers
	logic isRead;
	logic isWrite;

	// 8 KB region
	logic [15:13] region;

	assign isRead = nSwe;
	assign isWrite = ~nSwe;
	assign region = sa[15:13];

	//////////////////////////////////////////////////////////////////////
	// Selects, same map as the main CPU
	//////////////////////////////////////////////////////////////////////

	// Shared RAM windows
	assign nSCs2 = ~(region == 3'b000);
	assign nSCs0 = ~(region == 3'b001);
	assign nSCs1 = ~(region == 3'b010);

	// 6000h-7FFFh, read only
	assign nSCs4 = ~(isRead & (region == 3'b011));

	// Sub program ROM, upper half, read only
	assign nSRom = ~(isRead & sa[15]);

	//////////////////////////////////////////////////////////////////////
	// Write strobes
	//////////////////////////////////////////////////////////////////////

	// Sound chip register writes
	assign nSnd = ~(isWrite & (sa == addrGenPkg::pageSound));

	// Sub vblank interrupt acknowledge
	assign subAck = isWrite & (sa == addrGenPkg::pageSubAck);

endmodule

`default_nettype wire

// ==== logic/vblankSupervisor.sv ====
`default_nettype none

module vblankSupervisor #(
	parameter int wdWidth = 4,
	parameter int wdLimit = 10
) (
	input wire logic clk6M,
	input wire logic rstN,
	input wire logic nVbla,
	input wire logic wdKick,
	input wire logic mainAck,
	input wire logic subAck,
	output logic nMReset,
	output logic nMInt,
	output logic nSInt
);

	typedef logic [wdWidth-1:0] wdCount_t;

	// Vblank level from the previous edge
	logic nVblaQ;
	// Falling edge of vblank seen at this clock
	logic vblEvent;
	// A kick arrived since the last vblank
	logic kicked;
	wdCount_t wdCount;

	//////////////////////////////////////////////////////////////////////
	// Vblank edge detect
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk6M or negedge rstN) begin
		if (!rstN) begin
			nVblaQ <= 1'b1;
		end else begin
			nVblaQ <= nVbla;
		end
	end

	assign vblEvent = nVblaQ & ~nVbla;

	//////////////////////////////////////////////////////////////////////
	// Watchdog
	//////////////////////////////////////////////////////////////////////

	// Kicks are remembered for the rest of the frame
	always_ff @(posedge clk6M or negedge rstN) begin
		if (!rstN) begin
			kicked <= 1'b0;
		end else if (vblEvent) begin
			kicked <= 1'b0;
		end else if (wdKick) begin
			kicked <= 1'b1;
		end
	end

	// One step per frame
	// A kick on the vblank edge itself still counts
	always_ff @(posedge clk6M or negedge rstN) begin
		if (!rstN) begin
			wdCount <= '0;
		end else if (vblEvent) begin
			if (kicked | wdKick | (wdCount == wdCount_t'(wdLimit))) begin
				wdCount <= '0;
			end else begin
				wdCount <= wdCount + 1'b1;
			end
		end
	end

	// Top bit holds the main CPU in reset
	assign nMReset = ~wdCount[wdWidth-1];

	//////////////////////////////////////////////////////////////////////
	// Vblank interrupts
	//////////////////////////////////////////////////////////////////////

	// Vblank wins over an acknowledge on the same edge
	always_ff @(posedge clk6M or negedge rstN) begin
		if (!rstN) begin
			nMInt <= 1'b1;
			nSInt <= 1'b1;
		end else if (vblEvent) begin
			nMInt <= 1'b0;
			nSInt <= 1'b0;
		end else begin
			if (mainAck) begin
				nMInt <= 1'b1;
			end
			if (subAck) begin
				nSInt <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== test/cpuAddrGenTb.sv ====
`default_nettype none

module cpuAddrGenTb;
	timeunit 1ns;
	timeprecision 1ps;

	// Cycles used by all tests, with margin
	localparam int testCycles = 900;

	logic clk6M = 1'b0;
	logic rstN;
	logic clk0;
	addrGenPkg::addrPage_t ma;
	logic nMwe;
	addrGenPkg::addrPage_t sa;
	logic nSwe;
	logic nVbla;
	logic q;
	logic nMCs0, nMCs1, nMCs2, nMCs4, nMRom, nLth0, nLth1;
	logic nSCs0, nSCs1, nSCs2, nSCs4, nSRom, nSnd;
	logic nMReset, nMInt, nSInt;

	integer seed;
	logic [31:0] rnd;

	cpuAddrGen dut_i (
		.clk6M(clk6M), .rstN(rstN), .clk0(clk0), .ma(ma), .nMwe(nMwe),
		.sa(sa), .nSwe(nSwe), .nVbla(nVbla), .q(q),
		.nMCs0(nMCs0), .nMCs1(nMCs1), .nMCs2(nMCs2), .nMCs4(nMCs4),
		.nMRom(nMRom), .nLth0(nLth0), .nLth1(nLth1),
		.nSCs0(nSCs0), .nSCs1(nSCs1), .nSCs2(nSCs2), .nSCs4(nSCs4),
		.nSRom(nSRom), .nSnd(nSnd),
		.nMReset(nMReset), .nMInt(nMInt), .nSInt(nSInt)
	);

	// 40 ns period
	always #20 clk6M = ~clk6M;

	//////////////////////////////////////////////////////////////////////
	// Reporting and checks
	//////////////////////////////////////////////////////////////////////

	task automatic reportMismatch(input string name, input logic exp, input logic act);
		$display("ERR %0t ns %s expected %b actual %b", $time, name, exp, act);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic reportFailure(input string msg);
		$display("%0t ns %s", $time, msg);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic checkBit(input string name, input logic exp, input logic act);
		assert (act === exp) else reportMismatch(name, exp, act);
	endtask

	function automatic logic inRange(input logic [15:0] addr, input logic [15:0] lo,
			input logic [15:0] hi);
		return (addr >= lo) && (addr <= hi);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Reference address maps
	//////////////////////////////////////////////////////////////////////

	task automatic checkMainMap;
		logic [15:0] addr;
		logic rd;
		addr = {ma, 11'h000};
		rd = nMwe;
		checkBit("nMCs2", !inRange(addr, 16'h0000, 16'h1FFF), nMCs2);
		checkBit("nMCs0", !inRange(addr, 16'h2000, 16'h3FFF), nMCs0);
		checkBit("nMCs1", !inRange(addr, 16'h4000, 16'h5FFF), nMCs1);
		checkBit("nMCs4", !(rd && inRange(addr, 16'h6000, 16'h7FFF)), nMCs4);
		checkBit("nMRom", !(rd && inRange(addr, 16'h8000, 16'hFFFF)), nMRom);
		checkBit("nLth0", !(!rd && ma == addrGenPkg::pageLatch0), nLth0);
		checkBit("nLth1", !(!rd && ma == addrGenPkg::pageLatch1), nLth1);
	endtask

	task automatic checkSubMap;
		logic [15:0] addr;
		logic rd;
		addr = {sa, 11'h000};
		rd = nSwe;
		checkBit("nSCs2", !inRange(addr, 16'h0000, 16'h1FFF), nSCs2);
		checkBit("nSCs0", !inRange(addr, 16'h2000, 16'h3FFF), nSCs0);
		checkBit("nSCs1", !inRange(addr, 16'h4000, 16'h5FFF), nSCs1);
		checkBit("nSCs4", !(rd && inRange(addr, 16'h6000, 16'h7FFF)), nSCs4);
		checkBit("nSRom", !(rd && inRange(addr, 16'h8000, 16'hFFFF)), nSRom);
		checkBit("nSnd", !(!rd && sa == addrGenPkg::pageSound), nSnd);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Bus cycles
	//////////////////////////////////////////////////////////////////////

	// One write cycle, seen by the DUT at the second edge
	task automatic writePage(input logic toSub, input addrGenPkg::addrPage_t page);
		@(posedge clk6M);
		#5;
		if (toSub) begin
			sa = page;
			nSwe = 1'b0;
		end else begin
			ma = page;
			nMwe = 1'b0;
		end
		@(posedge clk6M);
		#5;
		nMwe = 1'b1;
		nSwe = 1'b1;
		@(negedge clk6M);
	endtask

	// Vblank low for one edge, event at that edge
	task automatic vblankPulse;
		@(posedge clk6M);
		#5;
		nVbla = 1'b0;
		@(posedge clk6M);
		#5;
		nVbla = 1'b1;
		@(negedge clk6M);
	endtask

	// Vblank event, then both acknowledges in turn
	task automatic frameWithAcks(input logic expReset);
		vblankPulse();
		checkBit("nMReset", expReset, nMReset);
		checkBit("nMInt", 1'b0, nMInt);
		checkBit("nSInt", 1'b0, nSInt);
		writePage(1'b0, addrGenPkg::pageMainAck);
		checkBit("nMInt", 1'b1, nMInt);
		checkBit("nSInt", 1'b0, nSInt);
		writePage(1'b1, addrGenPkg::pageSubAck);
		checkBit("nMInt", 1'b1, nMInt);
		checkBit("nSInt", 1'b1, nSInt);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin
		seed = 19611;
		rstN = 1'b0;
		clk0 = 1'b0;
		ma = '0;
		nMwe = 1'b1;
		sa = '0;
		nSwe = 1'b1;
		nVbla = 1'b1;
		repeat (10) @(posedge clk6M);
		#5;
		rstN = 1'b1;
		@(negedge clk6M);
		checkBit("nMReset", 1'b1, nMReset);
		checkBit("nMInt", 1'b1, nMInt);
		checkBit("nSInt", 1'b1, nSInt);
		checkBit("q", 1'b0, q);

		// Main map, q must stay low with clk0 low
		for (int i = 0; i < 300; i++) begin
			@(posedge clk6M);
			#5;
			rnd = $random(seed);
			ma = rnd[4:0];
			nMwe = rnd[5];
			@(negedge clk6M);
			checkMainMap();
			checkBit("q", 1'b0, q);
		end

		// Main CPU back to reads
		@(posedge clk6M);
		#5;
		nMwe = 1'b1;

		// Sub map
		for (int i = 0; i < 300; i++) begin
			@(posedge clk6M);
			#5;
			rnd = $random(seed);
			sa = rnd[4:0];
			nSwe = rnd[5];
			@(negedge clk6M);
			checkSubMap();
		end

		// Quadrature phase, high for two edges then low for two
		// Starts high at the first edge with clk0 high
		@(posedge clk6M);
		#5;
		nSwe = 1'b1;
		clk0 = 1'b1;
		for (int k = 0; k < 21; k++) begin
			@(posedge clk6M);
			if (k == 20) begin
				#5;
				clk0 = 1'b0;
			end
			@(negedge clk6M);
			checkBit("q", ((k + 1) % 4 == 1) || ((k + 1) % 4 == 2), q);
		end
		repeat (4) begin
			@(negedge clk6M);
			checkBit("q", 1'b0, q);
		end

		// Kicked frames keep the main CPU running
		for (int f = 0; f < 12; f++) begin
			writePage(1'b0, addrGenPkg::pageWdKick);
			frameWithAcks(1'b1);
		end

		// No kicks, reset low at events 8 to 10
		for (int ev = 1; ev <= 12; ev++) begin
			frameWithAcks(!(ev >= 8 && ev <= 10));
		end

		$display("all tests passed");
		$finish;
	end

	// Run limit
	initial begin
		#((testCycles + 200) * 40);
		reportFailure("timeout, the tests did not finish in time");
	end

endmodule

`default_nettype wire
